// File: pool3_params.svh
`ifndef POOL3_PARAMS_SVH
`define POOL3_PARAMS_SVH

// --------------------------------------------------------------------------
// Pixel and window geometry
// --------------------------------------------------------------------------

`define POOL_PIX_W      16                  // Unsigned pixel
`define POOL_ROWS       8                   // Rows per input column
`define POOL_CHANNELS   2                   // Channels per row
`define POOL_OUT_ROWS   3                   // Windows start at rows 0, 2, 4

// Nine pixels sum to less than 16 times full scale
`define POOL_ACC_W      (`POOL_PIX_W + 4)

`endif

// File: pool3_pkg.sv
package pool3_pkg;

`include "pool3_params.svh"

	// ----------------------------------------------------------------------
	// Scalar types
	// ----------------------------------------------------------------------

	typedef logic [`POOL_PIX_W-1:0] pix_t;     // One pixel
	typedef logic [`POOL_ACC_W-1:0] acc_t;     // Partial max or sum

	typedef enum logic {
		POOL_MAX = 1'b0,
		POOL_AVG = 1'b1
	} pool_mode_e;

	// ----------------------------------------------------------------------
	// Column types with row 0 in the low bits
	// ----------------------------------------------------------------------

	// Input beat of rows by channels
	typedef pix_t [`POOL_ROWS-1:0][`POOL_CHANNELS-1:0] column_t;

	// One entry per pooled row after the vertical reduction
	typedef acc_t [`POOL_OUT_ROWS-1:0][`POOL_CHANNELS-1:0] red_column_t;

	// Pooled output beat
	typedef pix_t [`POOL_OUT_ROWS-1:0][`POOL_CHANNELS-1:0] out_column_t;

	// Unsigned compare shared by both pooling directions
	function automatic acc_t acc_max(acc_t a, acc_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

// File: pool3_col_reduce.sv
`include "pool3_params.svh"

module pool3_col_reduce (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic                   in_first,
	input  pool3_pkg::pool_mode_e  in_mode,
	input  pool3_pkg::column_t     in_column,
	output logic                   red_valid,
	output logic                   red_first,
	output pool3_pkg::pool_mode_e  red_mode,
	output pool3_pkg::red_column_t red_column
);

	import pool3_pkg::*;

	red_column_t red_next;

	// ----------------------------------------------------------------------
	// Vertical 3-row windows at stride 2
	// ----------------------------------------------------------------------

	always_comb begin
		acc_t row_a;
		acc_t row_b;
		acc_t row_c;

		for (int k = 0; k < `POOL_OUT_ROWS; k++) begin
			for (int c = 0; c < `POOL_CHANNELS; c++) begin
				row_a = acc_t'(in_column[2*k][c]);         // Top row of window
				row_b = acc_t'(in_column[2*k+1][c]);
				row_c = acc_t'(in_column[2*k+2][c]);       // Shared with next window
				if (in_mode == POOL_AVG) begin
					red_next[k][c] = row_a + row_b + row_c;
				end else begin
					red_next[k][c] = acc_max(acc_max(row_a, row_b), row_c);
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Stage register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			red_valid <= 1'b0;
			red_first <= 1'b0;
			red_mode  <= POOL_MAX;
		end else begin
			red_valid <= in_valid;
			if (in_valid) begin
				red_first <= in_first;
				red_mode  <= in_mode;                     // Travels with the data
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			red_column <= red_next;
		end
	end

endmodule

// File: pool3_row_window.sv
`include "pool3_params.svh"

module pool3_row_window (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   red_valid,
	input  logic                   red_first,
	input  pool3_pkg::pool_mode_e  red_mode,
	input  pool3_pkg::red_column_t red_column,
	output logic                   win_valid,
	output pool3_pkg::pool_mode_e  win_mode,
	output pool3_pkg::red_column_t win_sum
);

	import pool3_pkg::*;

	logic [15:0] col_idx;                      // Index of last accepted column
	logic [15:0] cur_idx;                      // Index of arriving column
	logic        close_win;
	pool_mode_e  line_mode;                    // Mode of the current line
	red_column_t col_prev;                     // Column at cur_idx - 1
	red_column_t col_prev2;                    // Column at cur_idx - 2
	red_column_t win_next;

	// ----------------------------------------------------------------------
	// Column index and window close
	// ----------------------------------------------------------------------

	assign cur_idx = red_first ? 16'd0 : col_idx + 16'd1;

	// Even and at least 2
	assign close_win = red_valid && !cur_idx[0] && (cur_idx[15:1] != 15'd0);

	always_comb begin
		for (int k = 0; k < `POOL_OUT_ROWS; k++) begin
			for (int c = 0; c < `POOL_CHANNELS; c++) begin
				if (red_mode == POOL_AVG) begin
					win_next[k][c] = col_prev2[k][c] + col_prev[k][c] + red_column[k][c];
				end else begin
					win_next[k][c] = acc_max(acc_max(col_prev2[k][c], col_prev[k][c]),
						red_column[k][c]);
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Column history
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_idx   <= 16'd0;
			line_mode <= POOL_MAX;
			col_prev  <= '0;
			col_prev2 <= '0;
		end else if (red_valid) begin
			col_idx   <= cur_idx;
			line_mode <= red_mode;
			col_prev  <= red_column;
			col_prev2 <= col_prev;                    // Shift by one column
		end
	end

	// ----------------------------------------------------------------------
	// Window register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_valid <= 1'b0;
			win_mode  <= POOL_MAX;
		end else begin
			win_valid <= close_win;                   // One pulse per window
			if (close_win) begin
				win_mode <= red_mode;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (close_win) begin
			win_sum <= win_next;
		end
	end

	// The mode pin may only change at a line boundary
	a_mode_per_line: assert property (@(posedge clk) disable iff (!rst_n)
		red_valid && !red_first |-> red_mode == line_mode)
		else $error("pooling mode changed inside a line");

endmodule

// File: pool3_avg_scale.sv
`include "pool3_params.svh"

module pool3_avg_scale (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   win_valid,
	input  pool3_pkg::pool_mode_e  win_mode,
	input  pool3_pkg::red_column_t win_sum,
	output logic                   out_valid,
	output pool3_pkg::out_column_t out_column
);

	import pool3_pkg::*;

	out_column_t out_next;
	logic        upper_clear;                  // No bits above pixel width

	// ----------------------------------------------------------------------
	// Divide by about 9 as S * (1/16 + 1/32 + 1/64)
	// ----------------------------------------------------------------------

	always_comb begin
		acc_t s;
		acc_t scaled;

		upper_clear = 1'b1;
		for (int k = 0; k < `POOL_OUT_ROWS; k++) begin
			for (int c = 0; c < `POOL_CHANNELS; c++) begin
				s      = win_sum[k][c];
				scaled = (s >> 4) + (s >> 5) + (s >> 6);
				if (win_mode == POOL_AVG) begin
					out_next[k][c] = pix_t'(scaled);      // Truncate to pixel
				end else begin
					out_next[k][c] = pix_t'(s);
				end
				if (s[`POOL_ACC_W-1:`POOL_PIX_W] != '0) begin
					upper_clear = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= win_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			out_column <= out_next;                   // Held between windows
		end
	end

	// A max of zero-extended pixels never reaches the guard bits
	a_max_fits_pixel: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid && win_mode == POOL_MAX |-> upper_clear)
		else $error("max window exceeds pixel width");

endmodule

// File: pool3_top.sv
module pool3_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic                   in_first,
	input  pool3_pkg::pool_mode_e  in_mode,
	input  pool3_pkg::column_t     in_column,
	output logic                   out_valid,
	output pool3_pkg::out_column_t out_column
);

	import pool3_pkg::*;

	// Vertical stage to horizontal stage
	logic        red_valid;
	logic        red_first;
	pool_mode_e  red_mode;
	red_column_t red_column;

	// Horizontal stage to result stage
	logic        win_valid;
	pool_mode_e  win_mode;
	red_column_t win_sum;

	pool3_col_reduce u_col_reduce (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_first   (in_first),
		.in_mode    (in_mode),
		.in_column  (in_column),
		.red_valid  (red_valid),
		.red_first  (red_first),
		.red_mode   (red_mode),
		.red_column (red_column)
	);

	pool3_row_window u_row_window (
		.clk        (clk),
		.rst_n      (rst_n),
		.red_valid  (red_valid),
		.red_first  (red_first),
		.red_mode   (red_mode),
		.red_column (red_column),
		.win_valid  (win_valid),
		.win_mode   (win_mode),
		.win_sum    (win_sum)
	);

	pool3_avg_scale u_avg_scale (
		.clk        (clk),
		.rst_n      (rst_n),
		.win_valid  (win_valid),
		.win_mode   (win_mode),
		.win_sum    (win_sum),
		.out_valid  (out_valid),
		.out_column (out_column)
	);

endmodule

// File: tb_pool3_clock.sv
module tb_pool3_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;                           // 8 ns period

endmodule

// File: tb_pool3.sv
module tb_pool3;

	timeunit 1ns;
	timeprecision 1ps;

	import pool3_pkg::*;

	localparam string       DATA_FILE    = "pool3_testdata.txt";
	localparam logic [31:0] LFSR_SEED    = 32'h9927430f;
	localparam logic [31:0] LFSR_TAPS    = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1
	localparam int          DRAIN_CYCLES = 8;              // Pipeline is 3 deep

	// Characters that matter in the data file
	localparam int CH_EOF  = -1;
	localparam int CH_LF   = 10;
	localparam int CH_HASH = 35;
	localparam int CH_E    = 69;
	localparam int CH_I    = 73;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_first;
	pool_mode_e  in_mode;
	column_t     in_column;
	logic        out_valid;
	out_column_t out_column;

	logic        beat_first[$];
	pool_mode_e  beat_mode[$];
	column_t     beat_column[$];
	out_column_t exp_column[$];
	int          exp_cycle[$];                      // Cycle with out_valid high

	logic [31:0] lfsr_state;
	int          cycle_cnt;
	int          cycle_limit;

	tb_pool3_clock clk_gen (
		.clk (clk)
	);

	pool3_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_first   (in_first),
		.in_mode    (in_mode),
		.in_column  (in_column),
		.out_valid  (out_valid),
		.out_column (out_column)
	);

	// ------------------------------------------------------------------------
	// Failure reporting and compare
	// ------------------------------------------------------------------------

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_failure(input string reason);
		$display("%s", reason);
		abort_run();
	endtask

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// Random gaps and window rule
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] nxt;

		nxt = state >> 1;
		if (state[0]) begin
			nxt = nxt ^ LFSR_TAPS;
		end
		return nxt;
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);     // One step per bit
		end
	endtask

	// A window closes on even column indices from 2 upward
	function automatic logic closes_window(input int idx);
		return (idx % 2 == 0) && (idx >= 2);
	endfunction

	// ------------------------------------------------------------------------
	// Data file
	// ------------------------------------------------------------------------

	task automatic load_data();
		int           fd;
		int           ch;
		int           n;
		int           first_v;
		int           mode_v;
		int           line_idx;
		int           windows;
		logic [255:0] col_v;
		logic [95:0]  exp_v;
		logic         done;

		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			report_failure({"Cannot open data file ", DATA_FILE});
		end
		line_idx = 0;
		windows  = 0;
		done     = 1'b0;
		while (!done) begin
			ch = $fgetc(fd);
			if (ch == CH_EOF) begin
				done = 1'b1;
			end else if (ch == CH_HASH) begin
				while (ch != CH_LF && ch != CH_EOF) begin
					ch = $fgetc(fd);                // Skip comment text
				end
				if (ch == CH_EOF) begin
					done = 1'b1;
				end
			end else if (ch == CH_I) begin
				n = $fscanf(fd, "%d %d %h", first_v, mode_v, col_v);
				if (n != 3) begin
					report_failure("Malformed input line in data file");
				end
				beat_first.push_back(first_v != 0);
				beat_mode.push_back(mode_v != 0 ? POOL_AVG : POOL_MAX);
				beat_column.push_back(col_v);
				line_idx = (first_v != 0) ? 0 : line_idx + 1;
				if (closes_window(line_idx)) begin
					windows++;
				end
			end else if (ch == CH_E) begin
				n = $fscanf(fd, "%h", exp_v);
				if (n != 1) begin
					report_failure("Malformed expected line in data file");
				end
				exp_column.push_back(exp_v);
			end else if (ch > 32) begin
				report_failure("Unknown line tag in data file");
			end
		end
		$fclose(fd);
		if (beat_first.size() == 0) begin
			report_failure("Data file holds no input beats");
		end
		if (windows != exp_column.size()) begin
			report_failure($sformatf("Data file has %0d windows but %0d expected columns",
				windows, exp_column.size()));
		end
		cycle_limit = 4 * beat_first.size() + 50;   // Worst gap plus one beat each
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	task automatic drive_beats();
		int gap;
		int line_idx;

		line_idx = 0;
		for (int i = 0; i < beat_first.size(); i++) begin
			draw_bits(2, gap);                      // 0 to 3 idle cycles
			repeat (gap) begin
				@(posedge clk);
				#1;
				in_valid = 1'b0;
				in_first = 1'b0;
			end
			@(posedge clk);
			#1;
			in_valid  = 1'b1;
			in_first  = beat_first[i];
			in_mode   = beat_mode[i];
			in_column = beat_column[i];
			line_idx  = beat_first[i] ? 0 : line_idx + 1;
			if (closes_window(line_idx)) begin
				exp_cycle.push_back(cycle_cnt + 3);  // Three register stages
			end
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_first = 1'b0;
	endtask

	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_first   = 1'b0;
		in_mode    = POOL_MAX;
		in_column  = '0;
		lfsr_state = LFSR_SEED;
		load_data();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		drive_beats();
		repeat (DRAIN_CYCLES) @(posedge clk);
		if (exp_cycle.size() != 0) begin
			report_failure($sformatf("Missing outputs: %0d windows never appeared",
				exp_cycle.size()));
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Monitor and watchdog
	// ------------------------------------------------------------------------

	always @(negedge clk) begin
		if (!rst_n) begin
			check_value(128'(out_valid), 128'(1'b0), "out_valid during reset");
		end else if (out_valid === 1'b1) begin
			if (exp_cycle.size() == 0) begin
				report_failure($sformatf("Unexpected output at %0t ns, no window pending",
					$time));
			end else begin
				check_value(128'(cycle_cnt), 128'(exp_cycle.pop_front()),
					"output latency in cycles");
				check_value(128'(out_column), 128'(exp_column.pop_front()),
					"pooled output column");
			end
		end else begin
			check_value(128'(out_valid), 128'(1'b0), "out_valid idle level");
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			report_failure($sformatf("Timeout: run did not end within %0d cycles",
				cycle_limit));
		end
	end

endmodule

// File: pool3_testdata.txt
# I <first> <mode 0 max, 1 avg> <input column hex, row 7 channel 1 first, row 0 channel 0 last>
# E <expected output column hex, pooled row 2 channel 1 first, pooled row 0 channel 0 last>
# Max line of 7 columns, row 7 never pooled
I 1 0 0010001000100010001000100010001000100010001000100010001000100010
I 0 0 0020002000200020002000200020002000208000002000200020002000200020
I 0 0 0005000500050005000500051234000500050005000500050005000500050005
E 123400201234800000200020
I 0 0 ffff000300030003000300030003000300030003000300030003000300030003
I 0 0 0001000100010001000100010001000100010001000100010001000100010001
E 123400051234000500050005
I 0 0 0002000200020100000200020002000200020002000200020002000200020002
I 0 0 000400040004000400040004000400040004000400040004000400040004abcd
E 00040100000400040004abcd
# Average line, channel 0 at full scale
I 1 1 0017ffff0016ffff0015ffff0014ffff0013ffff0012ffff0011ffff0010ffff
I 0 1 0027ffff0026ffff0025ffff0024ffff0023ffff0022ffff0021ffff0020ffff
I 0 1 0037ffff0036ffff0035ffff0034ffff0033ffff0032ffff0031ffff0030ffff
E 0023fbfd0020fbfd001ffbfd
I 0 1 1007ffff1006ffff1005ffff1004ffff1003ffff1002ffff1001ffff1000ffff
I 0 1 2007ffff2006ffff2005ffff2004ffff2003ffff2002ffff2001ffff2000ffff
E 0fd2fbfd0fd1fbfd0fcffbfd
I 0 1 3007ffff3006ffff3005ffff3004ffff3003ffff3002ffff3001ffff3000ffff
I 0 1 4007ffff4006ffff4005ffff4004ffff4003ffff4002ffff4001ffff4000ffff
E 2f43fbfd2f41fbfd2f40fbfd
# Max line cut short after 4 columns
I 1 0 0700070007000700070007000700070007000700070007000700070007000700
I 0 0 0600060006000600060006000600060006000600060006000600060006000600
I 0 0 0500050005000500050005000500050005000500050005000500050005000500
E 070007000700070007000700
I 0 0 f000f000f000f000f000f000f000f000f000f000f000f000f000f000f000f000
# New max line where column 4 of the old line would have closed a window
I 1 0 0011001100110011001100110011001100110011001100110011001100110011
I 0 0 0033003300330033003300330033003300330033003300330033003300330033
I 0 0 0022002200220022002200440022002200220022002200220022002200220022
E 003300440033003300330033
I 0 0 0001000100010001000100010001000100010001000100010001000100010001
I 0 0 0002000200020002000200020002000200020002000200020002000200020002
E 002200440022002200220022

// File: pool3.f
+incdir+.
pool3_pkg.sv
pool3_col_reduce.sv
pool3_row_window.sv
pool3_avg_scale.sv
pool3_top.sv
tb_pool3_clock.sv
tb_pool3.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the pool3 testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pool3 -f pool3.f -o tb_pool3_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pool3_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished"
exit 0
